//--- hdl/rs_pkg.sv
`default_nettype none

// shared widths and unit numbering for the scheduling stage
package rs_pkg;

    // physical register tag
    localparam int PREG_W = 6;

    // architectural register number, rv32 has 32 of them
    localparam int AREG_W = 5;

    // reorder buffer index
    localparam int ROB_W = 6;

    // decode word, carried through untouched
    localparam int DECODE_W = 16;

    // unit classes, one bank and one bus channel each
    localparam int NUM_FU = 3;

    // unit indices
    // also the bank order and the bus channel order
    localparam logic [1:0] FU_ADD = 2'd0;
    localparam logic [1:0] FU_MUL = 2'd1;
    localparam logic [1:0] FU_DIV = 2'd2;

    // slots per bank unless the top level says otherwise
    localparam int DEFAULT_DEPTH = 8;

endpackage : rs_pkg

`default_nettype wire

//--- hdl/dispatch_router.sv
`timescale 1ns/1ps
`default_nettype none

// steers one dispatch into the bank named by rs_select
module dispatch_router (
    input  logic                      dispatch_valid,
    input  logic [1:0]                rs_select,
    input  logic [rs_pkg::NUM_FU-1:0] full,
    output logic [rs_pkg::NUM_FU-1:0] write
);

    import rs_pkg::*;

    logic [NUM_FU-1:0] sel_onehot; // decoded bank select

    always_comb
    begin
        sel_onehot = '0;
        if (dispatch_valid)
        begin
            case (rs_select)
                FU_ADD:
                begin
                    sel_onehot[FU_ADD] = 1'b1;
                end
                FU_MUL:
                begin
                    sel_onehot[FU_MUL] = 1'b1;
                end
                FU_DIV:
                begin
                    sel_onehot[FU_DIV] = 1'b1;
                end
                default:
                begin
                    sel_onehot = '0; // no bank behind select 3
                end
            endcase
        end
    end

    // a full bank drops the dispatch, dispatcher sees full already
    assign write = sel_onehot & ~full;

endmodule : dispatch_router

`default_nettype wire

//--- hdl/cdb_capture.sv
`timescale 1ns/1ps
`default_nettype none

// one register stage on the three bus channels
module cdb_capture (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [rs_pkg::PREG_W-1:0] cdb_tag [rs_pkg::NUM_FU],
    input  logic [rs_pkg::NUM_FU-1:0] cdb_we,
    output logic [rs_pkg::PREG_W-1:0] tag_q   [rs_pkg::NUM_FU],
    output logic [rs_pkg::NUM_FU-1:0] we_q
);

    import rs_pkg::*;

    // enables are the only control here
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            we_q <= '0;
        end
        else
        begin
            we_q <= cdb_we;
        end
    end

    // tags sampled on the same edge as their enables
    always_ff @(posedge clk)
    begin
        for (int k = 0; k < NUM_FU; k++)
        begin
            tag_q[k] <= cdb_tag[k];
        end
    end

endmodule : cdb_capture

`default_nettype wire

//--- hdl/rs_bank.sv
`timescale 1ns/1ps
`default_nettype none

// one reservation station bank in front of a single unit
module rs_bank #(
    parameter int DEPTH = rs_pkg::DEFAULT_DEPTH
) (
    input  logic                        clk,
    input  logic                        rst,

    // dispatch side
    input  logic                        write,
    input  logic                        ps1_ready,
    input  logic                        ps2_ready,
    input  logic [rs_pkg::PREG_W-1:0]   ps1,
    input  logic [rs_pkg::PREG_W-1:0]   ps2,
    input  logic [rs_pkg::PREG_W-1:0]   pd,
    input  logic [rs_pkg::AREG_W-1:0]   rd,
    input  logic [rs_pkg::ROB_W-1:0]    rob_index,
    input  logic [rs_pkg::DECODE_W-1:0] decode_info,

    // captured bus broadcasts
    input  logic [rs_pkg::PREG_W-1:0]   tag_q [rs_pkg::NUM_FU],
    input  logic [rs_pkg::NUM_FU-1:0]   we_q,

    // unit side
    input  logic                        fu_busy,
    output logic                        full,
    output logic                        issue_valid,
    output logic [rs_pkg::PREG_W-1:0]   issue_ps1,
    output logic [rs_pkg::PREG_W-1:0]   issue_ps2,
    output logic [rs_pkg::PREG_W-1:0]   issue_pd,
    output logic [rs_pkg::AREG_W-1:0]   issue_rd,
    output logic [rs_pkg::ROB_W-1:0]    issue_rob_index,
    output logic [rs_pkg::DECODE_W-1:0] issue_decode_info
);

    import rs_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    // per slot control
    logic [DEPTH-1:0] busy;
    logic [DEPTH-1:0] rdy1;
    logic [DEPTH-1:0] rdy2;

    // per slot payload
    logic [PREG_W-1:0]   slot_ps1    [DEPTH];
    logic [PREG_W-1:0]   slot_ps2    [DEPTH];
    logic [PREG_W-1:0]   slot_pd     [DEPTH];
    logic [AREG_W-1:0]   slot_rd     [DEPTH];
    logic [ROB_W-1:0]    slot_rob    [DEPTH];
    logic [DECODE_W-1:0] slot_decode [DEPTH];

    logic [DEPTH-1:0] wake1;   // tag match on source 1 this edge
    logic [DEPTH-1:0] wake2;

    logic             free_found;
    logic [IDX_W-1:0] free_idx;
    logic             pick_found;
    logic [IDX_W-1:0] pick_idx;

    // lowest empty slot
    always_comb
    begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = 0; i < DEPTH; i++)
        begin
            if (!busy[i] && !free_found)
            begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    assign full = ~free_found;

    // oldest slot index wins, both operands must be ready
    always_comb
    begin
        pick_found = 1'b0;
        pick_idx   = '0;
        for (int i = 0; i < DEPTH; i++)
        begin
            if (busy[i] && rdy1[i] && rdy2[i] && !pick_found)
            begin
                pick_found = 1'b1;
                pick_idx   = IDX_W'(i);
            end
        end
    end

    // compare every source tag against all three channels
    always_comb
    begin
        wake1 = '0;
        wake2 = '0;
        for (int i = 0; i < DEPTH; i++)
        begin
            for (int k = 0; k < NUM_FU; k++)
            begin
                if (we_q[k] && busy[i] && (slot_ps1[i] == tag_q[k]))
                begin
                    wake1[i] = 1'b1;
                end
                if (we_q[k] && busy[i] && (slot_ps2[i] == tag_q[k]))
                begin
                    wake2[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= '0;
            rdy1 <= '0;
            rdy2 <= '0;
        end
        else
        begin
            rdy1 <= rdy1 | wake1;
            rdy2 <= rdy2 | wake2;
            if (issue_valid)
            begin
                busy[pick_idx] <= 1'b0; // leaves for the unit
            end
            // written slot was empty, so no wakeup lands on it
            if (write)
            begin
                busy[free_idx] <= 1'b1;
                rdy1[free_idx] <= ps1_ready;
                rdy2[free_idx] <= ps2_ready;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (write)
        begin
            slot_ps1[free_idx]    <= ps1;
            slot_ps2[free_idx]    <= ps2;
            slot_pd[free_idx]     <= pd;
            slot_rd[free_idx]     <= rd;
            slot_rob[free_idx]    <= rob_index;
            slot_decode[free_idx] <= decode_info;
        end
    end

    // held back while the unit is busy
    assign issue_valid = pick_found & ~fu_busy;

    assign issue_ps1         = slot_ps1[pick_idx];
    assign issue_ps2         = slot_ps2[pick_idx];
    assign issue_pd          = slot_pd[pick_idx];
    assign issue_rd          = slot_rd[pick_idx];
    assign issue_rob_index   = slot_rob[pick_idx];
    assign issue_decode_info = slot_decode[pick_idx];

endmodule : rs_bank

`default_nettype wire

//--- hdl/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

// scheduling stage: add, multiply and divide banks
module reservation_station #(
    parameter int DEPTH = rs_pkg::DEFAULT_DEPTH
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        dispatch_valid,
    input  logic [1:0]                  rs_select,
    input  logic                        ps1_ready,
    input  logic                        ps2_ready,
    input  logic [rs_pkg::PREG_W-1:0]   ps1,
    input  logic [rs_pkg::PREG_W-1:0]   ps2,
    input  logic [rs_pkg::PREG_W-1:0]   pd,
    input  logic [rs_pkg::AREG_W-1:0]   rd,
    input  logic [rs_pkg::ROB_W-1:0]    rob_index,
    input  logic [rs_pkg::DECODE_W-1:0] decode_info,

    input  logic [rs_pkg::PREG_W-1:0]   cdb_tag [rs_pkg::NUM_FU],
    input  logic [rs_pkg::NUM_FU-1:0]   cdb_we,
    input  logic [rs_pkg::NUM_FU-1:0]   fu_busy,

    output logic [rs_pkg::NUM_FU-1:0]   full,
    output logic [rs_pkg::NUM_FU-1:0]   issue_valid,
    output logic [rs_pkg::PREG_W-1:0]   issue_ps1         [rs_pkg::NUM_FU],
    output logic [rs_pkg::PREG_W-1:0]   issue_ps2         [rs_pkg::NUM_FU],
    output logic [rs_pkg::PREG_W-1:0]   issue_pd          [rs_pkg::NUM_FU],
    output logic [rs_pkg::AREG_W-1:0]   issue_rd          [rs_pkg::NUM_FU],
    output logic [rs_pkg::ROB_W-1:0]    issue_rob_index   [rs_pkg::NUM_FU],
    output logic [rs_pkg::DECODE_W-1:0] issue_decode_info [rs_pkg::NUM_FU]
);

    import rs_pkg::*;

    logic [NUM_FU-1:0] bank_write;          // one-hot dispatch strobe
    logic [PREG_W-1:0] cdb_tag_q [NUM_FU];  // registered broadcasts
    logic [NUM_FU-1:0] cdb_we_q;

    dispatch_router u_router (
        .dispatch_valid (dispatch_valid),
        .rs_select      (rs_select),
        .full           (full),
        .write          (bank_write)
    );

    cdb_capture u_cdb (
        .clk     (clk),
        .rst     (rst),
        .cdb_tag (cdb_tag),
        .cdb_we  (cdb_we),
        .tag_q   (cdb_tag_q),
        .we_q    (cdb_we_q)
    );

    // bank k feeds unit k, all banks see every bus channel
    for (genvar k = 0; k < NUM_FU; k++)
    begin : g_bank
        rs_bank #(
            .DEPTH (DEPTH)
        ) u_bank (
            .clk               (clk),
            .rst               (rst),
            .write             (bank_write[k]),
            .ps1_ready         (ps1_ready),
            .ps2_ready         (ps2_ready),
            .ps1               (ps1),
            .ps2               (ps2),
            .pd                (pd),
            .rd                (rd),
            .rob_index         (rob_index),
            .decode_info       (decode_info),
            .tag_q             (cdb_tag_q),
            .we_q              (cdb_we_q),
            .fu_busy           (fu_busy[k]),
            .full              (full[k]),
            .issue_valid       (issue_valid[k]),
            .issue_ps1         (issue_ps1[k]),
            .issue_ps2         (issue_ps2[k]),
            .issue_pd          (issue_pd[k]),
            .issue_rd          (issue_rd[k]),
            .issue_rob_index   (issue_rob_index[k]),
            .issue_decode_info (issue_decode_info[k])
        );
    end

endmodule : reservation_station

`default_nettype wire

//--- testbench/rs_checker.sv
`timescale 1ns/1ps
`default_nettype none

// samples the DUT mid cycle and compares against the data file values
module rs_checker (
    input  logic                           clk,
    input  logic                           check_en,
    input  logic                           done,
    input  logic [63:0]                    test_name,
    input  logic [rs_pkg::NUM_FU-1:0]      exp_full,
    input  logic [rs_pkg::NUM_FU-1:0]      exp_iv,
    input  logic [rs_pkg::NUM_FU-1:0][55:0] exp_issue,
    input  logic [rs_pkg::NUM_FU-1:0]      full,
    input  logic [rs_pkg::NUM_FU-1:0]      issue_valid,
    input  logic [rs_pkg::PREG_W-1:0]      issue_ps1         [rs_pkg::NUM_FU],
    input  logic [rs_pkg::PREG_W-1:0]      issue_ps2         [rs_pkg::NUM_FU],
    input  logic [rs_pkg::PREG_W-1:0]      issue_pd          [rs_pkg::NUM_FU],
    input  logic [rs_pkg::AREG_W-1:0]      issue_rd          [rs_pkg::NUM_FU],
    input  logic [rs_pkg::ROB_W-1:0]       issue_rob_index   [rs_pkg::NUM_FU],
    input  logic [rs_pkg::DECODE_W-1:0]    issue_decode_info [rs_pkg::NUM_FU],
    output int                             error_count,
    output logic                           report_done
);

    import rs_pkg::*;

    logic [63:0] cur_name;
    int          test_errors;
    int          test_cycles;
    int          tests_passed;
    int          tests_failed;

    initial
    begin
        cur_name     = '0;
        test_errors  = 0;
        test_cycles  = 0;
        tests_passed = 0;
        tests_failed = 0;
        error_count  = 0;
        report_done  = 1'b0;
    end

    // same byte lanes as the fields column of the data file
    function automatic logic [55:0] pack_fields(input int k);
        logic [55:0] word;
        word = '0;
        word[48 +: PREG_W]   = issue_ps1[k];
        word[40 +: PREG_W]   = issue_ps2[k];
        word[32 +: PREG_W]   = issue_pd[k];
        word[24 +: AREG_W]   = issue_rd[k];
        word[16 +: ROB_W]    = issue_rob_index[k];
        word[0 +: DECODE_W]  = issue_decode_info[k];
        return word;
    endfunction

    task automatic close_test();
        if (cur_name != '0)
        begin
            if (test_errors == 0)
            begin
                $display("test %0s passed in %0d cycles", cur_name, test_cycles);
                tests_passed++;
            end
            else
            begin
                $display("test %0s had %0d mismatches", cur_name, test_errors);
                tests_failed++;
            end
        end
        test_errors = 0;
        test_cycles = 0;
    endtask

    task automatic compare_line();
        logic [55:0] actual;
        test_cycles++;
        if (full !== exp_full)
        begin
            $display("[FAIL] %0s: full expected %h actual %h", cur_name, exp_full, full);
            test_errors++;
            error_count++;
        end
        if (issue_valid !== exp_iv)
        begin
            $display("[FAIL] %0s: issue_valid expected %h actual %h",
                     cur_name, exp_iv, issue_valid);
            test_errors++;
            error_count++;
        end
        for (int k = 0; k < NUM_FU; k++)
        begin
            actual = pack_fields(k);
            if (exp_iv[k] && actual !== exp_issue[k]) // fields only matter on issue
            begin
                $display("[FAIL] %0s: unit %0d issue fields expected %h actual %h",
                         cur_name, k, exp_issue[k], actual);
                test_errors++;
                error_count++;
            end
        end
    endtask

    // negedge, so inputs and outputs have settled
    always @(negedge clk)
    begin
        if (check_en)
        begin
            if (test_name != cur_name)
            begin
                close_test();
                cur_name = test_name;
            end
            compare_line();
        end
        else if (done && !report_done)
        begin
            close_test();
            $display("summary: %0d tests passed, %0d tests failed, %0d mismatches",
                     tests_passed, tests_failed, error_count);
            report_done = 1'b1;
        end
    end

endmodule : rs_checker

`default_nettype wire

//--- testbench/tb_reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

// drives the scheduling stage from the data file, one line per clock
module tb_reservation_station;

    import rs_pkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_MARGIN = 20;
    localparam int DEPTH          = 4;  // small bank so the full test stays short
    localparam     DATA_FILE      = "testbench/rs_testdata.txt";

    logic                clk;
    logic                rst;
    logic                dispatch_valid;
    logic [1:0]          rs_select;
    logic                ps1_ready;
    logic                ps2_ready;
    logic [PREG_W-1:0]   ps1;
    logic [PREG_W-1:0]   ps2;
    logic [PREG_W-1:0]   pd;
    logic [AREG_W-1:0]   rd;
    logic [ROB_W-1:0]    rob_index;
    logic [DECODE_W-1:0] decode_info;
    logic [PREG_W-1:0]   cdb_tag [NUM_FU];
    logic [NUM_FU-1:0]   cdb_we;
    logic [NUM_FU-1:0]   fu_busy;

    logic [NUM_FU-1:0]   full;
    logic [NUM_FU-1:0]   issue_valid;
    logic [PREG_W-1:0]   issue_ps1         [NUM_FU];
    logic [PREG_W-1:0]   issue_ps2         [NUM_FU];
    logic [PREG_W-1:0]   issue_pd          [NUM_FU];
    logic [AREG_W-1:0]   issue_rd          [NUM_FU];
    logic [ROB_W-1:0]    issue_rob_index   [NUM_FU];
    logic [DECODE_W-1:0] issue_decode_info [NUM_FU];

    // expected values handed to the checker
    logic                   check_en;
    logic                   done;
    logic [63:0]            test_name;
    logic [NUM_FU-1:0]      exp_full;
    logic [NUM_FU-1:0]      exp_iv;
    logic [NUM_FU-1:0][55:0] exp_issue;
    int                     error_count;
    logic                   report_done;

    string lines [$];
    int    bad_lines;
    int    limit;
    int    cycle_count;

    reservation_station #(
        .DEPTH (DEPTH)
    ) u_dut (
        .clk               (clk),
        .rst               (rst),
        .dispatch_valid    (dispatch_valid),
        .rs_select         (rs_select),
        .ps1_ready         (ps1_ready),
        .ps2_ready         (ps2_ready),
        .ps1               (ps1),
        .ps2               (ps2),
        .pd                (pd),
        .rd                (rd),
        .rob_index         (rob_index),
        .decode_info       (decode_info),
        .cdb_tag           (cdb_tag),
        .cdb_we            (cdb_we),
        .fu_busy           (fu_busy),
        .full              (full),
        .issue_valid       (issue_valid),
        .issue_ps1         (issue_ps1),
        .issue_ps2         (issue_ps2),
        .issue_pd          (issue_pd),
        .issue_rd          (issue_rd),
        .issue_rob_index   (issue_rob_index),
        .issue_decode_info (issue_decode_info)
    );

    rs_checker u_checker (
        .clk               (clk),
        .check_en          (check_en),
        .done              (done),
        .test_name         (test_name),
        .exp_full          (exp_full),
        .exp_iv            (exp_iv),
        .exp_issue         (exp_issue),
        .full              (full),
        .issue_valid       (issue_valid),
        .issue_ps1         (issue_ps1),
        .issue_ps2         (issue_ps2),
        .issue_pd          (issue_pd),
        .issue_rd          (issue_rd),
        .issue_rob_index   (issue_rob_index),
        .issue_decode_info (issue_decode_info),
        .error_count       (error_count),
        .report_done       (report_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // keeps every data line that is not a comment
    task automatic read_testdata();
        int    fd;
        string line;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0)
        begin
            $display("could not open %s for reading", DATA_FILE);
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() > 1 && line.getc(0) != "#")
                begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_line(input string line, input int idx);
        logic [63:0] name;
        logic [3:0]  dv, sel, r1, r2, we, busy, efull, eiv;
        logic [55:0] fields, ea, em, ed;
        logic [7:0]  t0, t1, t2;
        int          n;
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name, dv, sel, r1, r2, fields, t0, t1, t2, we, busy,
                    efull, eiv, ea, em, ed);
        if (n != 16)
        begin
            $display("data line %0d could not be parsed, only %0d fields found", idx, n);
            bad_lines++;
        end
        rst            <= 1'b0;
        check_en       <= (n == 16);
        dispatch_valid <= (n == 16) && dv[0];
        rs_select      <= sel[1:0];
        ps1_ready      <= r1[0];
        ps2_ready      <= r2[0];
        ps1            <= fields[48 +: PREG_W];  // one byte lane per field
        ps2            <= fields[40 +: PREG_W];
        pd             <= fields[32 +: PREG_W];
        rd             <= fields[24 +: AREG_W];
        rob_index      <= fields[16 +: ROB_W];
        decode_info    <= fields[0 +: DECODE_W];
        cdb_tag[0]     <= t0[PREG_W-1:0];
        cdb_tag[1]     <= t1[PREG_W-1:0];
        cdb_tag[2]     <= t2[PREG_W-1:0];
        cdb_we         <= we[NUM_FU-1:0];
        fu_busy        <= busy[NUM_FU-1:0];
        test_name      <= name;
        exp_full       <= efull[NUM_FU-1:0];
        exp_iv         <= eiv[NUM_FU-1:0];
        exp_issue[0]   <= ea;
        exp_issue[1]   <= em;
        exp_issue[2]   <= ed;
    endtask

    initial
    begin
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        rs_select      = '0;
        ps1_ready      = 1'b0;
        ps2_ready      = 1'b0;
        ps1            = '0;
        ps2            = '0;
        pd             = '0;
        rd             = '0;
        rob_index      = '0;
        decode_info    = '0;
        for (int k = 0; k < NUM_FU; k++)
        begin
            cdb_tag[k] = '0;
        end
        cdb_we    = '0;
        fu_busy   = '0;
        check_en  = 1'b0;
        done      = 1'b0;
        test_name = '0;
        exp_full  = '0;
        exp_iv    = '0;
        exp_issue = '0;
        bad_lines = 0;
        read_testdata();
        if (lines.size() == 0)
        begin
            $display("no stimulus lines were read from %s", DATA_FILE);
            $display("CHECKS FAILED");
            $finish;
        end
        else
        begin
            limit = lines.size() + RESET_CYCLES + TIMEOUT_MARGIN;
            repeat (RESET_CYCLES) @(posedge clk);
            foreach (lines[i])
            begin
                apply_line(lines[i], i);
                @(posedge clk);
            end
            dispatch_valid <= 1'b0;
            cdb_we         <= '0;
            fu_busy        <= '0;
            check_en       <= 1'b0;
            done           <= 1'b1;  // checker closes the last test
            wait (report_done);
            if (error_count == 0 && bad_lines == 0)
            begin
                $display("ALL CHECKS PASSED");
            end
            else
            begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

    // limit is known once the data file has been read
    initial
    begin
        cycle_count = 0;
        wait (limit > 0);
        while (cycle_count < limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timed out after %0d cycles before the data file was done", limit);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule : tb_reservation_station

`default_nettype wire

//--- testbench/rs_testdata.txt
# name valid select rdy1 rdy2 fields(ps1 ps2 pd rd rob bytes, decode low 16) tag0 tag1 tag2 cdb_we fu_busy
# then expected full, issue_valid and issue fields of add, mul, div (0 where nothing issues)
disp  1 0 1 1 0102030405a001 00 00 00 0 0  0 0 0 0 0
disp  1 1 1 1 0607080906b002 00 00 00 0 0  0 1 0102030405a001 0 0
disp  1 2 1 1 0b0c0d0e07c003 00 00 00 0 0  0 2 0 0607080906b002 0
disp  0 0 0 0 0 00 00 00 0 0  0 4 0 0 0b0c0d0e07c003
disp  0 0 0 0 0 00 00 00 0 0  0 0 0 0 0
wake  1 0 0 1 1011121308d004 00 00 00 0 0  0 0 0 0 0
wake  1 1 1 0 1420151609e005 10 00 00 0 0  0 0 0 0 0
wake  1 2 0 0 212223170af006 00 00 00 0 0  0 0 0 0 0
wake  0 0 0 0 0 21 20 10 7 0  0 0 0 0 0
wake  0 0 0 0 0 00 00 22 4 0  0 0 0 0 0
wake  0 0 0 0 0 00 00 00 0 0  0 3 1011121308d004 1420151609e005 0
wake  0 0 0 0 0 00 00 00 0 0  0 4 0 0 212223170af006
wake  0 0 0 0 0 00 00 00 0 0  0 0 0 0 0
prio  1 0 1 1 30313201101001 00 00 00 0 1  0 0 0 0 0
prio  1 0 1 1 33343502112002 00 00 00 0 1  0 0 0 0 0
prio  1 0 1 1 36373803123003 00 00 00 0 1  0 0 0 0 0
prio  0 0 0 0 0 00 00 00 0 1  0 0 0 0 0
prio  0 0 0 0 0 00 00 00 0 0  0 1 30313201101001 0 0
prio  0 0 0 0 0 00 00 00 0 1  0 0 0 0 0
prio  0 0 0 0 0 00 00 00 0 0  0 1 33343502112002 0 0
prio  0 0 0 0 0 00 00 00 0 0  0 1 36373803123003 0 0
prio  0 0 0 0 0 00 00 00 0 0  0 0 0 0 0
full  1 1 0 1 3a002000204000 00 00 00 0 0  0 0 0 0 0
full  1 1 0 1 3a002101214001 00 00 00 0 0  0 0 0 0 0
full  1 1 0 1 3a002202224002 00 00 00 0 0  0 0 0 0 0
full  1 1 0 1 3a002303234003 00 00 00 0 0  0 0 0 0 0
full  1 1 0 1 3a002404244004 00 00 00 0 0  2 0 0 0 0
full  0 0 0 0 0 00 3a 00 2 0  2 0 0 0 0
full  0 0 0 0 0 00 00 00 0 0  2 0 0 0 0
full  0 0 0 0 0 00 00 00 0 0  2 2 0 3a002000204000 0
full  0 0 0 0 0 00 00 00 0 0  0 2 0 3a002101214001 0
full  0 0 0 0 0 00 00 00 0 0  0 2 0 3a002202224002 0
full  0 0 0 0 0 00 00 00 0 0  0 2 0 3a002303234003 0
full  0 0 0 0 0 00 00 00 0 0  0 0 0 0 0
indep 1 3 1 1 3f3f3f1f3fffff 00 00 00 0 0  0 0 0 0 0
indep 1 0 1 1 0405060708aa11 00 00 00 0 0  0 0 0 0 0
indep 1 1 1 1 090a0b0c0dbb22 00 00 00 0 7  0 0 0 0 0
indep 1 2 1 1 0e0f101112cc33 00 00 00 0 7  0 0 0 0 0
indep 0 0 0 0 0 00 00 00 0 0  0 7 0405060708aa11 090a0b0c0dbb22 0e0f101112cc33
indep 0 0 0 0 0 00 00 00 0 0  0 0 0 0 0

//--- reservation_station.f
hdl/rs_pkg.sv
hdl/dispatch_router.sv
hdl/cdb_capture.sv
hdl/rs_bank.sv
hdl/reservation_station.sv
testbench/rs_checker.sv
testbench/tb_reservation_station.sv
